//--- Bender.yml
package:
  name: flit_buffer

sources:
  - verilog/flit_buffer_pkg.sv
  - verilog/vc_ptr_bank.sv
  - verilog/vc_occupancy.sv
  - verilog/flit_store.sv
  - verilog/flit_buffer.sv
  - target: simulation
    files:
      - sim/flit_buffer_assertions.sv
      - sim/tb_flit_buffer.sv

//--- filelist.f
verilog/flit_buffer_pkg.sv
verilog/vc_ptr_bank.sv
verilog/vc_occupancy.sv
verilog/flit_store.sv
verilog/flit_buffer.sv
sim/flit_buffer_assertions.sv
sim/tb_flit_buffer.sv

//--- sim/flit_buffer_assertions.sv
`default_nettype none

module flit_buffer_assertions (
    input logic                       clk,
    input logic                       reset,
    input flit_buffer_pkg::vc_mask_t  wr_vc,
    input logic                       wr_en,
    input flit_buffer_pkg::vc_mask_t  rd_vc,
    input logic                       rd_en,
    input flit_buffer_pkg::vc_count_t vc_count [flit_buffer_pkg::NUM_VC]
);

    import flit_buffer_pkg::*;

    // per-VC illegal access flags
    vc_mask_t full_write;
    vc_mask_t empty_read;

    // failure tallies per assertion
    int wr_onehot_fails;
    int rd_onehot_fails;
    int overflow_fails;
    int underflow_fails;
    int fail_count;

    assign fail_count = wr_onehot_fails + rd_onehot_fails + overflow_fails + underflow_fails;

    always_comb begin
        for (int i = 0; i < NUM_VC; i++) begin
            // a full VC may only take a flit if it gives one up in the same cycle
            full_write[i] = wr_en && wr_vc[i] && (vc_count[i] == COUNT_W'(VC_DEPTH))
                            && !(rd_en && rd_vc[i]);
            empty_read[i] = rd_en && rd_vc[i] && (vc_count[i] == '0);
        end
    end

    wr_vc_onehot: assert property (@(posedge clk) disable iff (reset) wr_en |-> $onehot(wr_vc))
        else begin
            $error("write VC mask %b is not one-hot", wr_vc);
            wr_onehot_fails++;
        end

    rd_vc_onehot: assert property (@(posedge clk) disable iff (reset) rd_en |-> $onehot(rd_vc))
        else begin
            $error("read VC mask %b is not one-hot", rd_vc);
            rd_onehot_fails++;
        end

    no_overflow: assert property (@(posedge clk) disable iff (reset) full_write == '0)
        else begin
            $error("write to a full VC, mask %b", full_write);
            overflow_fails++;
        end

    no_underflow: assert property (@(posedge clk) disable iff (reset) empty_read == '0)
        else begin
            $error("read from an empty VC, mask %b", empty_read);
            underflow_fails++;
        end

endmodule

bind vc_occupancy flit_buffer_assertions u_occ_assert (
    .clk      (clk),
    .reset    (reset),
    .wr_vc    (wr_vc),
    .wr_en    (wr_en),
    .rd_vc    (rd_vc),
    .rd_en    (rd_en),
    .vc_count (vc_count)
);

`default_nettype wire

//--- sim/tb_flit_buffer.sv
`default_nettype none

module tb_flit_buffer;

    import flit_buffer_pkg::*;

    // test lengths in clock cycles
    localparam int RESET_CYCLES  = 16;
    localparam int SINGLE_CYCLES = 3;
    localparam int FILL_CYCLES   = 4 * VC_DEPTH + 1;
    localparam int HOLD_CYCLES   = VC_DEPTH + 5;
    localparam int RANDOM_STEPS  = 300;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 1 + SINGLE_CYCLES + FILL_CYCLES
                                   + HOLD_CYCLES + RANDOM_STEPS + 1;

    logic         clk = 1'b0;
    logic         reset;
    logic         wr_en;
    vc_mask_t     wr_vc;
    flit_t        din;
    logic         rd_en;
    vc_mask_t     rd_vc;
    stored_flit_t dout;
    vc_mask_t     vc_not_empty;

    // reference model, one queue per VC
    stored_flit_t model_q [NUM_VC][$];
    vc_mask_t     pend_mask = '0;    // model mask after the last driven op
    stored_flit_t last_dout;
    logic         have_last = 1'b0;

    logic [31:0] rng_state = 32'h9a51_0627;
    string       cur_test;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          errors_at_start;

    flit_buffer DUT (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_vc        (wr_vc),
        .din          (din),
        .rd_en        (rd_en),
        .rd_vc        (rd_vc),
        .dout         (dout),
        .vc_not_empty (vc_not_empty)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic flit_t rand_flit();
        flit_t       f;
        logic [31:0] r;
        r           = next_rand();
        f.flit_type = r[FLIT_TYPE_W-1:0];
        f.vc        = vc_mask_t'(r[31:16]);    // junk, the DUT must ignore it
        f.payload   = next_rand();
        return f;
    endfunction

    function automatic vc_mask_t model_mask();
        vc_mask_t m;
        m = '0;
        for (int i = 0; i < NUM_VC; i++) begin
            m[i] = (model_q[i].size() != 0);
        end
        return m;
    endfunction

    task automatic check_flit(input string name, input stored_flit_t exp, input stored_flit_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error in %s: dout expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_vc_mask(input string name, input vc_mask_t exp, input vc_mask_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error in %s: vc_not_empty expected %b, actual %b", name, exp, act);
        end
    endtask

    // one clock cycle: drive this op, check the previous one
    task automatic step(input logic w, input int wi, input flit_t f, input logic r, input int ri);
        vc_mask_t     wv;
        vc_mask_t     rv;
        stored_flit_t sf;
        wv = w ? (vc_mask_t'(1) << wi) : '0;
        rv = r ? (vc_mask_t'(1) << ri) : '0;
        @(posedge clk);
        wr_en <= w;
        wr_vc <= wv;
        din   <= f;
        rd_en <= r;
        rd_vc <= rv;
        @(negedge clk);
        check_vc_mask(cur_test, pend_mask, vc_not_empty);
        if (have_last) begin
            check_flit(cur_test, last_dout, dout);    // new read or held value
        end
        if (r) begin
            last_dout = model_q[ri].pop_front();
            have_last = 1'b1;
        end
        if (w) begin
            sf.flit_type = f.flit_type;
            sf.payload   = f.payload;
            model_q[wi].push_back(sf);
        end
        pend_mask = model_mask();
    endtask

    task automatic idle(input int n);
        for (int k = 0; k < n; k++) begin
            step(1'b0, 0, '0, 1'b0, 0);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    // legal random traffic on all VCs, limited by the model's queue lengths
    task automatic random_traffic(input int n);
        logic [31:0] r;
        logic        do_wr;
        logic        do_rd;
        int          wi;
        int          ri;
        for (int k = 0; k < n; k++) begin
            r     = next_rand();
            do_rd = 1'b0;
            ri    = 0;
            if (r[0] && (model_mask() != '0)) begin
                ri = int'(r[15:8]) % NUM_VC;
                while (model_q[ri].size() == 0) begin
                    ri = (ri + 1) % NUM_VC;
                end
                do_rd = 1'b1;
            end
            wi    = (do_rd && r[3]) ? ri : int'(r[23:16]) % NUM_VC;    // same VC half the time
            do_wr = (r[1] || r[2])
                    && ((model_q[wi].size() < VC_DEPTH) || (do_rd && wi == ri));
            step(do_wr, wi, rand_flit(), do_rd, ri);
        end
        idle(1);
    endtask

    initial begin
        #(TOTAL_CYCLES * 10 * 2);
        $display("watchdog expired: the tests did not finish in %0d cycles", TOTAL_CYCLES * 2);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int total_errors;
        reset = 1'b1;
        wr_en = 1'b0;
        wr_vc = '0;
        din   = '0;
        rd_en = 1'b0;
        rd_vc = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        begin_test("reset");
        @(negedge clk);
        check_vc_mask(cur_test, '0, vc_not_empty);
        end_test();

        begin_test("single flit");
        step(1'b1, 2, rand_flit(), 1'b0, 0);
        step(1'b0, 0, '0, 1'b1, 2);
        idle(1);
        end_test();

        // VC 2 pointers start at 1 here, so the wrap lands mid-burst
        begin_test("fill and drain");
        for (int rep = 0; rep < 2; rep++) begin
            for (int k = 0; k < VC_DEPTH; k++) begin
                step(1'b1, 2, rand_flit(), 1'b0, 0);
            end
            for (int k = 0; k < VC_DEPTH; k++) begin
                step(1'b0, 0, '0, 1'b1, 2);
            end
        end
        idle(1);
        end_test();

        begin_test("dout hold");
        step(1'b1, 0, rand_flit(), 1'b0, 0);
        step(1'b0, 0, '0, 1'b1, 0);
        // vc0 refills until its last write lands on the slot just read
        for (int k = 0; k < VC_DEPTH; k++) begin
            step(1'b1, 0, rand_flit(), 1'b0, 0);
        end
        for (int k = 0; k < 2; k++) begin
            step(1'b1, 1, rand_flit(), 1'b0, 0);
        end
        idle(1);
        end_test();

        begin_test("random traffic");
        random_traffic(RANDOM_STEPS);
        end_test();

        total_errors = errors + DUT.u_occupancy.u_occ_assert.fail_count;
        $display("tests: %0d run, %0d failed; checks: %0d; errors: %0d; assertion failures: %0d",
                 tests, failed_tests, checks, errors, DUT.u_occupancy.u_occ_assert.fail_count);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/flit_buffer.sv
`default_nettype none

module flit_buffer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  flit_buffer_pkg::vc_mask_t     wr_vc,
    input  flit_buffer_pkg::flit_t        din,
    input  logic                          rd_en,
    input  flit_buffer_pkg::vc_mask_t     rd_vc,
    output flit_buffer_pkg::stored_flit_t dout,
    output flit_buffer_pkg::vc_mask_t     vc_not_empty
);

    import flit_buffer_pkg::*;

    mem_addr_t    wr_addr;
    mem_addr_t    rd_addr;
    stored_flit_t store_din;    // incoming flit without its VC field

    // wr_vc already picks the region, so din.vc is not kept
    assign store_din.flit_type = din.flit_type;
    assign store_din.payload   = din.payload;

    // write side pointers
    vc_ptr_bank u_wr_ptr (
        .clk     (clk),
        .reset   (reset),
        .vc_sel  (wr_vc),
        .advance (wr_en),
        .addr    (wr_addr)
    );

    // read side pointers
    vc_ptr_bank u_rd_ptr (
        .clk     (clk),
        .reset   (reset),
        .vc_sel  (rd_vc),
        .advance (rd_en),
        .addr    (rd_addr)
    );

    vc_occupancy u_occupancy (
        .clk          (clk),
        .reset        (reset),
        .wr_vc        (wr_vc),
        .wr_en        (wr_en),
        .rd_vc        (rd_vc),
        .rd_en        (rd_en),
        .vc_not_empty (vc_not_empty)
    );

    // shared memory, one cycle read latency
    flit_store u_store (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (store_din),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (dout)
    );

endmodule

`default_nettype wire

//--- verilog/flit_buffer_pkg.sv
`default_nettype none

package flit_buffer_pkg;

    // buffer geometry
    localparam int NUM_VC      = 4;
    localparam int VC_DEPTH    = 4;    // power of two only
    localparam int PAYLOAD_W   = 32;
    localparam int FLIT_TYPE_W = 2;    // header and tail markers

    // derived widths
    localparam int PTR_W   = $clog2(VC_DEPTH);
    localparam int VC_ID_W = $clog2(NUM_VC);
    localparam int COUNT_W = PTR_W + 1;    // counts 0 up to VC_DEPTH

    // one bit per virtual channel
    typedef logic [NUM_VC-1:0] vc_mask_t;

    // position inside one VC region
    typedef logic [PTR_W-1:0] vc_ptr_t;

    // region number on top, offset below
    typedef logic [VC_ID_W+PTR_W-1:0] mem_addr_t;

    // flits held by one VC
    typedef logic [COUNT_W-1:0] vc_count_t;

    // flit as seen on the write port
    typedef struct packed {
        logic [FLIT_TYPE_W-1:0] flit_type;
        vc_mask_t               vc;
        logic [PAYLOAD_W-1:0]   payload;
    } flit_t;

    // memory word, the VC is implied by the region
    typedef struct packed {
        logic [FLIT_TYPE_W-1:0] flit_type;
        logic [PAYLOAD_W-1:0]   payload;
    } stored_flit_t;

endpackage

`default_nettype wire

//--- verilog/flit_store.sv
`default_nettype none

module flit_store (
    input  logic                          clk,
    input  logic                          wr_en,
    input  flit_buffer_pkg::mem_addr_t    wr_addr,
    input  flit_buffer_pkg::stored_flit_t wr_data,
    input  logic                          rd_en,
    input  flit_buffer_pkg::mem_addr_t    rd_addr,
    output flit_buffer_pkg::stored_flit_t rd_data
);

    import flit_buffer_pkg::*;

    // all VC regions back to back, VC_DEPTH words each
    stored_flit_t mem [NUM_VC*VC_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, holds while rd_en is low
    // a read of the slot being written returns the old word,
    // which is the oldest flit of a full VC
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/vc_occupancy.sv
`default_nettype none

module vc_occupancy (
    input  logic                      clk,
    input  logic                      reset,
    input  flit_buffer_pkg::vc_mask_t wr_vc,
    input  logic                      wr_en,
    input  flit_buffer_pkg::vc_mask_t rd_vc,
    input  logic                      rd_en,
    output flit_buffer_pkg::vc_mask_t vc_not_empty
);

    import flit_buffer_pkg::*;

    // strobes qualified per VC
    vc_mask_t  wr;
    vc_mask_t  rd;

    // flits currently held by each VC
    vc_count_t vc_count [NUM_VC];

    assign wr = wr_en ? wr_vc : '0;
    assign rd = rd_en ? rd_vc : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_VC; i++) begin
                vc_count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_VC; i++) begin
                if (wr[i] && !rd[i]) begin
                    vc_count[i] <= vc_count[i] + 1'b1;
                end else if (!wr[i] && rd[i]) begin
                    vc_count[i] <= vc_count[i] - 1'b1;
                end
                // write and read together leave the count as is
            end
        end
    end

    // nonzero flag per VC
    always_comb begin
        for (int i = 0; i < NUM_VC; i++) begin
            vc_not_empty[i] = (vc_count[i] != '0);
        end
    end

endmodule

`default_nettype wire

//--- verilog/vc_ptr_bank.sv
`default_nettype none

module vc_ptr_bank (
    input  logic                       clk,
    input  logic                       reset,
    input  flit_buffer_pkg::vc_mask_t  vc_sel,
    input  logic                       advance,
    output flit_buffer_pkg::mem_addr_t addr
);

    import flit_buffer_pkg::*;

    // one circular pointer per VC region
    vc_ptr_t            ptr [NUM_VC];

    // binary VC number and the pointer of the selected VC
    logic [VC_ID_W-1:0] vc_id;
    vc_ptr_t            ptr_sel;

    // one-hot select folded into a binary id and a pointer mux
    always_comb begin
        vc_id   = '0;
        ptr_sel = '0;
        for (int i = 0; i < NUM_VC; i++) begin
            if (vc_sel[i]) begin
                vc_id   = vc_id | VC_ID_W'(i);
                ptr_sel = ptr_sel | ptr[i];
            end
        end
    end

    // region base from the VC id, offset from its pointer
    assign addr = {vc_id, ptr_sel};

    // only the selected pointer moves
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_VC; i++) begin
                ptr[i] <= '0;
            end
        end else if (advance) begin
            for (int i = 0; i < NUM_VC; i++) begin
                if (vc_sel[i]) begin
                    ptr[i] <= ptr[i] + 1'b1;    // wraps at VC_DEPTH
                end
            end
        end
    end

endmodule

`default_nettype wire
